//--- project.f
rs_types_pkg.sv
alu_ops_pkg.sv
reg_status_file.sv
rs_alu.sv
alu_unit.sv
alu_cluster_top.sv
tb_checker.sv
tb_alu_cluster.sv

//--- tb_alu_cluster.sv
`timescale 1ns/100ps

module tb_alu_cluster;

    localparam int WORD_W = 32;
    localparam int AW = rs_types_pkg::REG_ADDR_W;
    localparam int NREGS = 1 << AW;
    localparam int RST_CYCLES = 8;
    localparam int WARM_CYCLES = 40;
    localparam int STIM_CYCLES = 400;
    localparam int DRAIN_BOUND = 20;
    localparam int TOTAL_CYCLES = RST_CYCLES + STIM_CYCLES + DRAIN_BOUND + 2 * NREGS + 4;

    logic                           clk;
    logic                           rst;
    logic                           issue_en0;
    logic                           issue_en1;
    alu_ops_pkg::alu_op_e           op0;
    alu_ops_pkg::alu_op_e           op1;
    logic [AW-1:0]                  src_x0, src_y0, dst0;
    logic [AW-1:0]                  src_x1, src_y1, dst1;
    logic [AW-1:0]                  dbg_addr;
    logic                           check_regs;
    logic                           lane_busy0, lane_busy1;
    logic                           res_valid0, res_valid1;
    logic [rs_types_pkg::TAG_W-1:0] res_tag0, res_tag1;
    logic [WORD_W-1:0]              res_data0, res_data1;
    logic [AW-1:0]                  res_dst0, res_dst1;
    logic [WORD_W-1:0]              dbg_data;
    int                             data_errs, flow_errs, reg_errs;
    logic [31:0]                    lcg_state;

    alu_cluster_top #(.WORD_W(WORD_W)) dut (
        .clk(clk), .rst(rst),
        .issue_en0(issue_en0), .issue_en1(issue_en1), .op0(op0), .op1(op1),
        .src_x0(src_x0), .src_y0(src_y0), .dst0(dst0),
        .src_x1(src_x1), .src_y1(src_y1), .dst1(dst1),
        .dbg_addr(dbg_addr),
        .lane_busy0(lane_busy0), .lane_busy1(lane_busy1),
        .res_valid0(res_valid0), .res_valid1(res_valid1),
        .res_tag0(res_tag0), .res_tag1(res_tag1),
        .res_data0(res_data0), .res_data1(res_data1),
        .res_dst0(res_dst0), .res_dst1(res_dst1),
        .dbg_data(dbg_data)
    );

    tb_checker #(.WORD_W(WORD_W)) chk (
        .clk(clk), .rst(rst),
        .issue_en0(issue_en0), .issue_en1(issue_en1), .op0(op0), .op1(op1),
        .src_x0(src_x0), .src_y0(src_y0), .dst0(dst0),
        .src_x1(src_x1), .src_y1(src_y1), .dst1(dst1),
        .lane_busy0(lane_busy0), .lane_busy1(lane_busy1),
        .res_valid0(res_valid0), .res_valid1(res_valid1),
        .res_tag0(res_tag0), .res_tag1(res_tag1),
        .res_data0(res_data0), .res_data1(res_data1),
        .res_dst0(res_dst0), .res_dst1(res_dst1),
        .check_regs(check_regs), .dbg_addr(dbg_addr), .dbg_data(dbg_data),
        .data_errs(data_errs), .flow_errs(flow_errs), .reg_errs(reg_errs)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // One lane's instruction for the coming cycle, issued half the time when idle
    task automatic pick_instr(input bit warm, input logic busy, output logic en,
                              output alu_ops_pkg::alu_op_e op, output logic [AW-1:0] sx,
                              output logic [AW-1:0] sy, output logic [AW-1:0] d);
        logic [31:0] r;
        r = next_rand();
        en = !busy && r[31];
        if (warm) begin
            op = r[30] ? alu_ops_pkg::OP_ADD : alu_ops_pkg::OP_OR;
        end else begin
            op = alu_ops_pkg::alu_op_e'(r[30:28]);
        end
        sx = r[27:24];
        sy = r[23:20];
        d = r[19:16];
    endtask

    task automatic read_all_regs();
        check_regs = 1'b1;
        for (int r = 0; r < NREGS; r++) begin
            dbg_addr = AW'(r);
            @(negedge clk);
        end
        check_regs = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(40 * TOTAL_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", TOTAL_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        issue_en0 = 1'b0;
        issue_en1 = 1'b0;
        op0 = alu_ops_pkg::OP_ADD;
        op1 = alu_ops_pkg::OP_ADD;
        src_x0 = '0;
        src_y0 = '0;
        dst0 = '0;
        src_x1 = '0;
        src_y1 = '0;
        dst1 = '0;
        dbg_addr = '0;
        check_regs = 1'b0;
        lcg_state = 32'h29ff_405a;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        read_all_regs();     // All zero after reset
        for (int c = 0; c < STIM_CYCLES; c++) begin
            pick_instr(c < WARM_CYCLES, lane_busy0, issue_en0, op0, src_x0, src_y0, dst0);
            pick_instr(c < WARM_CYCLES, lane_busy1, issue_en1, op1, src_x1, src_y1, dst1);
            @(negedge clk);
        end
        issue_en0 = 1'b0;
        issue_en1 = 1'b0;
        while (lane_busy0 || lane_busy1) begin
            @(negedge clk);
        end
        read_all_regs();
        $display("Errors: data %0d, flow %0d, registers %0d", data_errs, flow_errs, reg_errs);
        if (data_errs + flow_errs + reg_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tb_checker.sv
`timescale 1ns/100ps

module tb_checker #(
    parameter int WORD_W = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_en0,
    input  logic                                 issue_en1,
    input  alu_ops_pkg::alu_op_e                 op0,
    input  alu_ops_pkg::alu_op_e                 op1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  src_x0, src_y0, dst0,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  src_x1, src_y1, dst1,
    input  logic                                 lane_busy0, lane_busy1,
    input  logic                                 res_valid0, res_valid1,
    input  logic [rs_types_pkg::TAG_W-1:0]       res_tag0, res_tag1,
    input  logic [WORD_W-1:0]                    res_data0, res_data1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  res_dst0, res_dst1,
    input  logic                                 check_regs,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  dbg_addr,
    input  logic [WORD_W-1:0]                    dbg_data,
    output int                                   data_errs,
    output int                                   flow_errs,
    output int                                   reg_errs
);

    localparam int NREGS = 1 << rs_types_pkg::REG_ADDR_W;

    logic [WORD_W-1:0]                    shadow [NREGS];     // In-order architectural state
    logic [WORD_W-1:0]                    exp_data0 [$];
    logic [WORD_W-1:0]                    exp_data1 [$];
    logic [rs_types_pkg::REG_ADDR_W-1:0]  exp_dst0 [$];
    logic [rs_types_pkg::REG_ADDR_W-1:0]  exp_dst1 [$];
    logic                                 exp_busy0;
    logic                                 exp_busy1;
    logic [WORD_W-1:0]                    v;

    function automatic logic [WORD_W-1:0] exec_op(input alu_ops_pkg::alu_op_e op,
                                                  input logic [WORD_W-1:0] x,
                                                  input logic [WORD_W-1:0] y);
        logic [4:0] sh;
        sh = y[4:0];
        case (op)
            alu_ops_pkg::OP_ADD: return x + y;
            alu_ops_pkg::OP_SUB: return x - y;
            alu_ops_pkg::OP_AND: return x & y;
            alu_ops_pkg::OP_OR:  return x | y;
            alu_ops_pkg::OP_XOR: return x ^ y;
            alu_ops_pkg::OP_SLL: return x << sh;
            alu_ops_pkg::OP_SRL: return x >> sh;
            alu_ops_pkg::OP_SLT: begin
                // Differing signs decide on their own
                if (x[WORD_W-1] != y[WORD_W-1]) begin
                    return {{(WORD_W-1){1'b0}}, x[WORD_W-1]};
                end
                return {{(WORD_W-1){1'b0}}, x < y};
            end
            default: return 'x;
        endcase
    endfunction

    task automatic compare_result(input int lane, input logic [WORD_W-1:0] got,
                                  input logic [WORD_W-1:0] exp,
                                  input logic [rs_types_pkg::REG_ADDR_W-1:0] got_dst,
                                  input logic [rs_types_pkg::REG_ADDR_W-1:0] exp_dst);
        if (got !== exp || got_dst !== exp_dst) begin
            $display("Fail %0t: lane %0d result %h to r%0d, expected %h to r%0d",
                     $time, lane, got, got_dst, exp, exp_dst);
            data_errs++;
        end
    endtask

    // Lane k broadcasts with tag k+1
    task automatic compare_tag(input int lane, input logic [rs_types_pkg::TAG_W-1:0] got);
        logic [rs_types_pkg::TAG_W-1:0] exp;
        exp = rs_types_pkg::TAG_W'(lane + 1);
        if (got !== exp) begin
            $display("Fail %0t: lane %0d result tag %0d, expected %0d", $time, lane, got, exp);
            data_errs++;
        end
    endtask

    task automatic compare_busy(input int lane, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t: lane %0d busy is %b, expected %b", $time, lane, got, exp);
            flow_errs++;
        end
    endtask

    task automatic report_stray(input int lane);
        $display("Lane %0d broadcast a result at %0t with nothing outstanding", lane, $time);
        flow_errs++;
    endtask

    initial begin
        data_errs = 0;
        flow_errs = 0;
        reg_errs = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NREGS; r++) begin
                shadow[r] = '0;
            end
            exp_busy0 = 1'b0;
            exp_busy1 = 1'b0;
            exp_data0.delete();
            exp_data1.delete();
            exp_dst0.delete();
            exp_dst1.delete();
        end else begin
            compare_busy(0, lane_busy0, exp_busy0);
            compare_busy(1, lane_busy1, exp_busy1);
            if (res_valid0 === 1'b1) begin
                compare_tag(0, res_tag0);
                if (exp_data0.size() == 0) begin
                    report_stray(0);
                end else begin
                    compare_result(0, res_data0, exp_data0.pop_front(),
                                   res_dst0, exp_dst0.pop_front());
                end
                exp_busy0 = 1'b0;     // Free in the next cycle
            end
            if (res_valid1 === 1'b1) begin
                compare_tag(1, res_tag1);
                if (exp_data1.size() == 0) begin
                    report_stray(1);
                end else begin
                    compare_result(1, res_data1, exp_data1.pop_front(),
                                   res_dst1, exp_dst1.pop_front());
                end
                exp_busy1 = 1'b0;
            end
            if (check_regs) begin
                if (dbg_data !== shadow[dbg_addr]) begin
                    $display("Fail %0t: r%0d reads %h, expected %h",
                             $time, dbg_addr, dbg_data, shadow[dbg_addr]);
                    reg_errs++;
                end
                if (dbg_addr == '0 && (exp_data0.size() != 0 || exp_data1.size() != 0)) begin
                    $display("Results are still outstanding when the registers are read");
                    flow_errs++;
                end
            end
            // Program order is lane 0 then lane 1
            if (issue_en0) begin
                v = exec_op(op0, shadow[src_x0], shadow[src_y0]);
                exp_data0.push_back(v);
                exp_dst0.push_back(dst0);
                shadow[dst0] = v;
                exp_busy0 = 1'b1;
            end
            if (issue_en1) begin
                v = exec_op(op1, shadow[src_x1], shadow[src_y1]);
                exp_data1.push_back(v);
                exp_dst1.push_back(dst1);
                shadow[dst1] = v;
                exp_busy1 = 1'b1;
            end
        end
    end

endmodule

//--- alu_cluster_top.sv
`timescale 1ns/100ps

module alu_cluster_top #(
    parameter int WORD_W = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_en0,
    input  logic                                 issue_en1,
    input  alu_ops_pkg::alu_op_e                 op0,
    input  alu_ops_pkg::alu_op_e                 op1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  src_x0,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  src_y0,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  dst0,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  src_x1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  src_y1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  dst1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  dbg_addr,
    output logic                                 lane_busy0,
    output logic                                 lane_busy1,
    output logic                                 res_valid0,
    output logic                                 res_valid1,
    output logic [rs_types_pkg::TAG_W-1:0]       res_tag0,
    output logic [rs_types_pkg::TAG_W-1:0]       res_tag1,
    output logic [WORD_W-1:0]                    res_data0,
    output logic [WORD_W-1:0]                    res_data1,
    output logic [rs_types_pkg::REG_ADDR_W-1:0]  res_dst0,
    output logic [rs_types_pkg::REG_ADDR_W-1:0]  res_dst1,
    output logic [WORD_W-1:0]                    dbg_data
);

    logic [rs_types_pkg::TAG_W-1:0]       tag_x0, tag_y0, tag_x1, tag_y1;
    logic [WORD_W-1:0]                    val_x0, val_y0, val_x1, val_y1;
    logic                                 disp_en0, disp_en1;
    alu_ops_pkg::alu_op_e                 disp_op0, disp_op1;
    logic [WORD_W-1:0]                    disp_x0, disp_y0, disp_x1, disp_y1;
    logic [rs_types_pkg::REG_ADDR_W-1:0]  disp_dst0, disp_dst1;

    assign res_tag0 = rs_types_pkg::lane_tag(0);     // Fixed per lane
    assign res_tag1 = rs_types_pkg::lane_tag(1);

    reg_status_file #(.WORD_W(WORD_W)) u_regs (
        .clk(clk), .rst(rst),
        .issue_en0(issue_en0), .issue_en1(issue_en1),
        .src_x0(src_x0), .src_y0(src_y0), .dst0(dst0),
        .src_x1(src_x1), .src_y1(src_y1), .dst1(dst1),
        .res_valid0(res_valid0), .res_valid1(res_valid1),
        .res_dst0(res_dst0), .res_dst1(res_dst1),
        .res_data0(res_data0), .res_data1(res_data1),
        .dbg_addr(dbg_addr),
        .tag_x0(tag_x0), .tag_y0(tag_y0), .tag_x1(tag_x1), .tag_y1(tag_y1),
        .val_x0(val_x0), .val_y0(val_y0), .val_x1(val_x1), .val_y1(val_y1),
        .dbg_data(dbg_data)
    );

    rs_alu #(.WORD_W(WORD_W)) u_rs (
        .clk(clk), .rst(rst),
        .issue_en0(issue_en0), .issue_en1(issue_en1),
        .op0(op0), .op1(op1),
        .tag_x0(tag_x0), .tag_y0(tag_y0), .tag_x1(tag_x1), .tag_y1(tag_y1),
        .val_x0(val_x0), .val_y0(val_y0), .val_x1(val_x1), .val_y1(val_y1),
        .dst0(dst0), .dst1(dst1),
        .res_valid0(res_valid0), .res_valid1(res_valid1),
        .res_data0(res_data0), .res_data1(res_data1),
        .lane_busy0(lane_busy0), .lane_busy1(lane_busy1),
        .disp_en0(disp_en0), .disp_en1(disp_en1),
        .disp_op0(disp_op0), .disp_op1(disp_op1),
        .disp_x0(disp_x0), .disp_y0(disp_y0), .disp_x1(disp_x1), .disp_y1(disp_y1),
        .disp_dst0(disp_dst0), .disp_dst1(disp_dst1)
    );

    alu_unit #(.WORD_W(WORD_W)) alu0 (
        .clk(clk), .rst(rst),
        .disp_en(disp_en0), .disp_op(disp_op0),
        .disp_x(disp_x0), .disp_y(disp_y0), .disp_dst(disp_dst0),
        .res_valid(res_valid0), .res_data(res_data0), .res_dst(res_dst0)
    );

    alu_unit #(.WORD_W(WORD_W)) alu1 (
        .clk(clk), .rst(rst),
        .disp_en(disp_en1), .disp_op(disp_op1),
        .disp_x(disp_x1), .disp_y(disp_y1), .disp_dst(disp_dst1),
        .res_valid(res_valid1), .res_data(res_data1), .res_dst(res_dst1)
    );

endmodule

//--- alu_unit.sv
`timescale 1ns/100ps

module alu_unit #(
    parameter int WORD_W = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 disp_en,
    input  alu_ops_pkg::alu_op_e                 disp_op,
    input  logic [WORD_W-1:0]                    disp_x,
    input  logic [WORD_W-1:0]                    disp_y,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  disp_dst,
    output logic                                 res_valid,
    output logic [WORD_W-1:0]                    res_data,
    output logic [rs_types_pkg::REG_ADDR_W-1:0]  res_dst
);

    logic [WORD_W-1:0] result;
    logic [4:0]        shamt;

    assign shamt = disp_y[4:0];

    always_comb begin
        case (disp_op)
            alu_ops_pkg::OP_ADD: result = disp_x + disp_y;
            alu_ops_pkg::OP_SUB: result = disp_x - disp_y;
            alu_ops_pkg::OP_AND: result = disp_x & disp_y;
            alu_ops_pkg::OP_OR:  result = disp_x | disp_y;
            alu_ops_pkg::OP_XOR: result = disp_x ^ disp_y;
            alu_ops_pkg::OP_SLL: result = disp_x << shamt;
            alu_ops_pkg::OP_SRL: result = disp_x >> shamt;
            alu_ops_pkg::OP_SLT: result = WORD_W'($signed(disp_x) < $signed(disp_y));
            default:             result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= disp_en;     // One cycle pulse per dispatch
        end
    end

    always_ff @(posedge clk) begin
        if (disp_en) begin
            res_data <= result;
            res_dst <= disp_dst;
        end
    end

    // Station must not dispatch again before the broadcast
    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        res_valid |=> !res_valid);

endmodule

//--- rs_alu.sv
`timescale 1ns/100ps

module rs_alu #(
    parameter int WORD_W = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_en0,
    input  logic                                 issue_en1,
    input  alu_ops_pkg::alu_op_e                 op0,
    input  alu_ops_pkg::alu_op_e                 op1,
    input  logic [rs_types_pkg::TAG_W-1:0]       tag_x0,
    input  logic [rs_types_pkg::TAG_W-1:0]       tag_y0,
    input  logic [rs_types_pkg::TAG_W-1:0]       tag_x1,
    input  logic [rs_types_pkg::TAG_W-1:0]       tag_y1,
    input  logic [WORD_W-1:0]                    val_x0,
    input  logic [WORD_W-1:0]                    val_y0,
    input  logic [WORD_W-1:0]                    val_x1,
    input  logic [WORD_W-1:0]                    val_y1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  dst0,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  dst1,
    input  logic                                 res_valid0,
    input  logic                                 res_valid1,
    input  logic [WORD_W-1:0]                    res_data0,
    input  logic [WORD_W-1:0]                    res_data1,
    output logic                                 lane_busy0,
    output logic                                 lane_busy1,
    output logic                                 disp_en0,
    output logic                                 disp_en1,
    output alu_ops_pkg::alu_op_e                 disp_op0,
    output alu_ops_pkg::alu_op_e                 disp_op1,
    output logic [WORD_W-1:0]                    disp_x0,
    output logic [WORD_W-1:0]                    disp_y0,
    output logic [WORD_W-1:0]                    disp_x1,
    output logic [WORD_W-1:0]                    disp_y1,
    output logic [rs_types_pkg::REG_ADDR_W-1:0]  disp_dst0,
    output logic [rs_types_pkg::REG_ADDR_W-1:0]  disp_dst1
);

    localparam int L = rs_types_pkg::LANES;
    localparam int TW = rs_types_pkg::TAG_W;

    logic                                 in_en [L];
    alu_ops_pkg::alu_op_e                 in_op [L];
    logic [TW-1:0]                        in_tag_x [L];
    logic [TW-1:0]                        in_tag_y [L];
    logic [WORD_W-1:0]                    in_val_x [L];
    logic [WORD_W-1:0]                    in_val_y [L];
    logic [rs_types_pkg::REG_ADDR_W-1:0]  in_dst [L];
    logic                                 bc_valid [L];
    logic [WORD_W-1:0]                    bc_data [L];

    // Entry state
    logic                                 busy [L];
    logic                                 sent [L];
    alu_ops_pkg::alu_op_e                 op [L];
    logic [TW-1:0]                        tag_x [L];
    logic [TW-1:0]                        tag_y [L];
    logic [WORD_W-1:0]                    val_x [L];
    logic [WORD_W-1:0]                    val_y [L];
    logic [rs_types_pkg::REG_ADDR_W-1:0]  dst [L];

    logic [TW-1:0]                        nx_tag_x [L];
    logic [TW-1:0]                        nx_tag_y [L];
    logic [WORD_W-1:0]                    nx_val_x [L];
    logic [WORD_W-1:0]                    nx_val_y [L];
    logic                                 fire [L];

    assign in_en = '{issue_en0, issue_en1};
    assign in_op = '{op0, op1};
    assign in_tag_x = '{tag_x0, tag_x1};
    assign in_tag_y = '{tag_y0, tag_y1};
    assign in_val_x = '{val_x0, val_x1};
    assign in_val_y = '{val_y0, val_y1};
    assign in_dst = '{dst0, dst1};
    assign bc_valid = '{res_valid0, res_valid1};
    assign bc_data = '{res_data0, res_data1};

    // Operand source, then snoop both broadcasts
    always_comb begin
        for (int k = 0; k < L; k++) begin
            nx_tag_x[k] = in_en[k] ? in_tag_x[k] : tag_x[k];
            nx_val_x[k] = in_en[k] ? in_val_x[k] : val_x[k];
            nx_tag_y[k] = in_en[k] ? in_tag_y[k] : tag_y[k];
            nx_val_y[k] = in_en[k] ? in_val_y[k] : val_y[k];
            for (int b = 0; b < L; b++) begin
                if (bc_valid[b] && nx_tag_x[k] == rs_types_pkg::lane_tag(b)) begin
                    nx_tag_x[k] = rs_types_pkg::TAG_NONE;
                    nx_val_x[k] = bc_data[b];
                end
                if (bc_valid[b] && nx_tag_y[k] == rs_types_pkg::lane_tag(b)) begin
                    nx_tag_y[k] = rs_types_pkg::TAG_NONE;
                    nx_val_y[k] = bc_data[b];
                end
            end
            fire[k] = busy[k] && !sent[k] && tag_x[k] == rs_types_pkg::TAG_NONE
                      && tag_y[k] == rs_types_pkg::TAG_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < L; k++) begin
                busy[k] <= 1'b0;
                sent[k] <= 1'b0;
            end
        end else begin
            for (int k = 0; k < L; k++) begin
                if (in_en[k]) begin
                    busy[k] <= 1'b1;
                    sent[k] <= 1'b0;
                end else begin
                    if (fire[k]) begin
                        sent[k] <= 1'b1;
                    end
                    if (bc_valid[k]) begin
                        busy[k] <= 1'b0;     // Free after own broadcast
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < L; k++) begin
            tag_x[k] <= nx_tag_x[k];
            tag_y[k] <= nx_tag_y[k];
            val_x[k] <= nx_val_x[k];
            val_y[k] <= nx_val_y[k];
            if (in_en[k]) begin
                op[k] <= in_op[k];
                dst[k] <= in_dst[k];
            end
        end
    end

    assign lane_busy0 = busy[0];
    assign lane_busy1 = busy[1];
    assign disp_en0 = fire[0];
    assign disp_en1 = fire[1];
    assign disp_op0 = op[0];
    assign disp_op1 = op[1];
    assign disp_x0 = val_x[0];
    assign disp_y0 = val_y[0];
    assign disp_x1 = val_x[1];
    assign disp_y1 = val_y[1];
    assign disp_dst0 = dst[0];
    assign disp_dst1 = dst[1];

    for (genvar k = 0; k < L; k++) begin : g_chk
        a_issue_idle: assert property (@(posedge clk) disable iff (rst)
            in_en[k] |-> !busy[k]);
        // One dispatch per busy entry
        a_disp_busy: assert property (@(posedge clk) disable iff (rst)
            fire[k] |-> busy[k] ##1 !fire[k]);
    end

endmodule

//--- reg_status_file.sv
`timescale 1ns/100ps

module reg_status_file #(
    parameter int WORD_W = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_en0,
    input  logic                                 issue_en1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  src_x0,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  src_y0,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  dst0,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  src_x1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  src_y1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  dst1,
    input  logic                                 res_valid0,
    input  logic                                 res_valid1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  res_dst0,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  res_dst1,
    input  logic [WORD_W-1:0]                    res_data0,
    input  logic [WORD_W-1:0]                    res_data1,
    input  logic [rs_types_pkg::REG_ADDR_W-1:0]  dbg_addr,
    output logic [rs_types_pkg::TAG_W-1:0]       tag_x0,
    output logic [rs_types_pkg::TAG_W-1:0]       tag_y0,
    output logic [rs_types_pkg::TAG_W-1:0]       tag_x1,
    output logic [rs_types_pkg::TAG_W-1:0]       tag_y1,
    output logic [WORD_W-1:0]                    val_x0,
    output logic [WORD_W-1:0]                    val_y0,
    output logic [WORD_W-1:0]                    val_x1,
    output logic [WORD_W-1:0]                    val_y1,
    output logic [WORD_W-1:0]                    dbg_data
);

    localparam int NREGS = 1 << rs_types_pkg::REG_ADDR_W;

    logic [WORD_W-1:0]                    regs [NREGS];
    logic [rs_types_pkg::TAG_W-1:0]       tags [NREGS];
    logic [rs_types_pkg::REG_ADDR_W-1:0]  src [4];         // x0, y0, x1, y1
    logic [rs_types_pkg::TAG_W-1:0]       look_tag [4];
    logic [WORD_W-1:0]                    look_val [4];

    assign src[0] = src_x0;
    assign src[1] = src_y0;
    assign src[2] = src_x1;
    assign src[3] = src_y1;

    always_comb begin
        logic [rs_types_pkg::TAG_W-1:0] cur;
        for (int i = 0; i < 4; i++) begin
            cur = tags[src[i]];
            look_tag[i] = cur;
            look_val[i] = regs[src[i]];
            if (res_valid0 && cur == rs_types_pkg::lane_tag(0)) begin     // Bypass lane 0 result
                look_tag[i] = rs_types_pkg::TAG_NONE;
                look_val[i] = res_data0;
            end else if (res_valid1 && cur == rs_types_pkg::lane_tag(1)) begin
                look_tag[i] = rs_types_pkg::TAG_NONE;
                look_val[i] = res_data1;
            end
            // Lane 1 is younger and sees lane 0's rename
            if (i >= 2 && issue_en0 && src[i] == dst0) begin
                look_tag[i] = rs_types_pkg::lane_tag(0);
            end
        end
    end

    assign tag_x0 = look_tag[0];
    assign tag_y0 = look_tag[1];
    assign tag_x1 = look_tag[2];
    assign tag_y1 = look_tag[3];
    assign val_x0 = look_val[0];
    assign val_y0 = look_val[1];
    assign val_x1 = look_val[2];
    assign val_y1 = look_val[3];

    assign dbg_data = regs[dbg_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NREGS; r++) begin
                regs[r] <= '0;
                tags[r] <= rs_types_pkg::TAG_NONE;
            end
        end else begin
            // Stale broadcasts are dropped
            if (res_valid0 && tags[res_dst0] == rs_types_pkg::lane_tag(0)) begin
                regs[res_dst0] <= res_data0;
                tags[res_dst0] <= rs_types_pkg::TAG_NONE;
            end
            if (res_valid1 && tags[res_dst1] == rs_types_pkg::lane_tag(1)) begin
                regs[res_dst1] <= res_data1;
                tags[res_dst1] <= rs_types_pkg::TAG_NONE;
            end
            if (issue_en0) begin
                tags[dst0] <= rs_types_pkg::lane_tag(0);
            end
            if (issue_en1) begin
                tags[dst1] <= rs_types_pkg::lane_tag(1);     // Lane 1 wins on same dst
            end
        end
    end

endmodule

//--- alu_ops_pkg.sv
package alu_ops_pkg;

    localparam int OP_W = 3;

    typedef enum logic [OP_W-1:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,     // Shift by y[4:0]
        OP_SRL,
        OP_SLT      // Signed compare
    } alu_op_e;

endpackage

//--- rs_types_pkg.sv
package rs_types_pkg;

    localparam int TAG_W = 2;
    localparam int REG_ADDR_W = 4;      // 16 architectural registers
    localparam int LANES = 2;

    localparam logic [TAG_W-1:0] TAG_NONE = '0;    // Value present, no producer pending

    // Lane k owns tag k+1
    function automatic logic [TAG_W-1:0] lane_tag(input int unsigned k);
        return TAG_W'(k + 1);
    endfunction

endpackage
